// File: bench/frame_feeder_tb.sv
module frame_feeder_tb
    import geom_pkg::*, scene_pkg::*;
();

    localparam int SEED       = 32'h5a1975d2;
    localparam int WAIT_LIMIT = 4000;
    localparam int INST_N     = 5;

    logic               clk;
    logic               rst;
    logic               wr_valid;
    scene_write_t       wr;
    logic               scene_ready;
    logic [INST_AW-1:0] inst_count;
    logic               setup_ready;
    logic               frame_start;
    logic               wr_ready;
    logic               setup_valid;
    setup_pkt_t         setup;
    logic               frame_done;

    // reference copies of the three tables
    inst_desc_t inst_model [1 << INST_AW];
    tri_idx_t   tri_model  [1 << TRI_AW];
    vertex_t    vert_model [1 << VERT_AW];
    setup_pkt_t expect_q   [$];

    int errors;
    int err_at_start;
    int tests_run;
    int tests_failed;
    int got_count;
    int want_count;

    frame_feeder frame_feeder_inst (
        .clk(clk), .rst(rst), .wr_valid(wr_valid), .wr(wr), .scene_ready(scene_ready),
        .inst_count(inst_count), .setup_ready(setup_ready), .frame_start(frame_start),
        .wr_ready(wr_ready), .setup_valid(setup_valid), .setup(setup), .frame_done(frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [255:0] got,
                                   input logic [255:0] want);
        $display("FAIL %s got %0h expected %0h", name, got, want);
        errors++;
    endtask

    task automatic log_error(input string what);
        $display("error: %s", what);
        errors++;
    endtask

    task automatic start_test();
        err_at_start = errors;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_at_start);
        end
    endtask

    task automatic write_entry(input table_sel_t sel, input int addr,
                               input logic [WR_DW-1:0] data);
        int   guard;
        logic taken;
        guard    = 0;
        taken    = 1'b0;
        wr_valid = 1'b1;
        wr.sel   = sel;
        wr.addr  = WR_AW'(addr);
        wr.data  = data;
        while (!taken && guard < WAIT_LIMIT) begin
            @(negedge clk);
            taken = wr_ready;
            @(posedge clk);
            #1;
            guard++;
        end
        wr_valid = 1'b0;
        assert (taken) else log_error("write channel never accepted a write");
    endtask

    function automatic inst_desc_t random_desc();
        inst_desc_t  d;
        logic [63:0] raw;
        raw         = {$urandom, $urandom};
        d.vert_base = VERT_AW'($urandom);
        d.tri_base  = TRI_AW'($urandom);
        d.tri_count = TRI_CNT_W'($urandom_range(0, 3));
        d.xform     = raw[43:0];
        d.bg_color  = raw[55:44];
        return d;
    endfunction

    task automatic load_tables();
        logic [63:0] raw;
        for (int i = 0; i < (1 << VERT_AW); i++) begin
            raw           = {$urandom, $urandom};
            vert_model[i] = raw[47:0];
            write_entry(SEL_VERT, i, WR_DW'(vert_model[i]));
        end
        for (int i = 0; i < (1 << TRI_AW); i++) begin
            raw          = {$urandom, $urandom};
            tri_model[i] = raw[23:0];
            write_entry(SEL_TRI, i, WR_DW'(tri_model[i]));
        end
        for (int i = 0; i < (1 << INST_AW); i++) begin
            inst_model[i] = random_desc();
            write_entry(SEL_INST, i, WR_DW'(inst_model[i]));
        end
    endtask

    function automatic vertex_t vertex_at(input logic [VERT_AW-1:0] base, input vidx_t idx);
        logic [VERT_AW-1:0] addr;
        addr = base + VERT_AW'(idx);
        return vert_model[addr];
    endfunction

    // camera first, then every triangle of instances 1..last in order
    task automatic predict_frame(input int last_inst);
        setup_pkt_t        pkt;
        tri_idx_t          ti;
        logic [TRI_AW-1:0] taddr;
        pkt          = '0;
        pkt.kind     = KIND_CAMERA;
        pkt.xform    = inst_model[0].xform;
        pkt.bg_color = inst_model[0].bg_color;
        expect_q.push_back(pkt);
        for (int k = 1; k <= last_inst; k++) begin
            for (int t = 0; t <= int'(inst_model[k].tri_count); t++) begin
                taddr           = inst_model[k].tri_base + TRI_AW'(t);
                ti              = tri_model[taddr];
                pkt             = '0;
                pkt.kind        = KIND_TRIANGLE;
                pkt.xform       = inst_model[k].xform;
                pkt.triangle.v0 = vertex_at(inst_model[k].vert_base, ti.i0);
                pkt.triangle.v1 = vertex_at(inst_model[k].vert_base, ti.i1);
                pkt.triangle.v2 = vertex_at(inst_model[k].vert_base, ti.i2);
                expect_q.push_back(pkt);
            end
        end
        want_count = expect_q.size();
        got_count  = 0;
    endtask

    task automatic check_packet(input setup_pkt_t pkt);
        setup_pkt_t want;
        if (expect_q.size() == 0) begin
            log_error("packet transferred when none was expected");
        end else begin
            want = expect_q.pop_front();
            got_count++;
            assert (pkt.kind == want.kind)
                else report_mismatch("setup.kind", pkt.kind, want.kind);
            assert (pkt.xform == want.xform)
                else report_mismatch("setup.xform", pkt.xform, want.xform);
            if (want.kind == KIND_CAMERA) begin
                assert (pkt.bg_color == want.bg_color)
                    else report_mismatch("setup.bg_color", pkt.bg_color, want.bg_color);
            end else begin
                assert (pkt.triangle == want.triangle)
                    else report_mismatch("setup.triangle", pkt.triangle, want.triangle);
            end
        end
    endtask

    // inputs settle at +1, so the falling edge sees the coming transfer
    always @(negedge clk) begin
        if (!rst && setup_valid && setup_ready) begin
            check_packet(setup);
        end
    end

    task automatic run_frame(input bit stall);
        int guard;
        guard = 0;
        while (!frame_done && guard < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            setup_ready = stall ? ($urandom_range(0, 2) != 0) : 1'b1;
            guard++;
        end
        setup_ready = 1'b1;
        assert (frame_done) else log_error("frame_done never rose");
        assert (got_count == want_count)
            else report_mismatch("packet count", got_count, want_count);
    endtask

    task automatic pulse_frame_start();
        frame_start = 1'b1;
        @(posedge clk);
        #1;
        frame_start = 1'b0;
    endtask

    setup_stable_under_stall: assert property (
        @(posedge clk) disable iff (rst)
        (setup_valid && !setup_ready) |=> (setup_valid && $stable(setup))
    ) else begin
        $display("error: setup changed or dropped before it was accepted");
        errors++;
    end

    done_holds_until_start: assert property (
        @(posedge clk) disable iff (rst)
        (frame_done && !frame_start) |=> frame_done
    ) else begin
        $display("error: frame_done dropped without frame_start");
        errors++;
    end

    done_clears_on_start: assert property (
        @(posedge clk) disable iff (rst)
        (frame_done && frame_start) |=> !frame_done
    ) else begin
        $display("error: frame_done stayed high after frame_start");
        errors++;
    end

    done_state_idle: assert property (
        @(posedge clk) disable iff (rst)
        frame_done |-> (wr_ready && !setup_valid)
    ) else begin
        $display("error: frame_done high with writes blocked or a packet pending");
        errors++;
    end

    initial begin
        void'($urandom(SEED));
        errors       = 0;
        err_at_start = 0;
        tests_run    = 0;
        tests_failed = 0;
        got_count    = 0;
        want_count   = 0;
        rst          = 1'b1;
        wr_valid     = 1'b0;
        wr           = '0;
        scene_ready  = 1'b0;
        inst_count   = '0;
        setup_ready  = 1'b1;
        frame_start  = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test();
        assert (setup_valid == 1'b0) else report_mismatch("setup_valid", setup_valid, 1'b0);
        assert (frame_done == 1'b0) else report_mismatch("frame_done", frame_done, 1'b0);
        assert (wr_ready == 1'b1) else report_mismatch("wr_ready", wr_ready, 1'b1);
        finish_test("reset_state");

        start_test();
        load_tables();
        finish_test("table_load");

        start_test();
        inst_count = INST_N;
        predict_frame(INST_N);
        scene_ready = 1'b1;
        run_frame(1'b0);
        finish_test("first_frame");

        // linger in DONE before restarting
        start_test();
        repeat (6) @(posedge clk);
        #1;
        predict_frame(INST_N);
        pulse_frame_start();
        run_frame(1'b1);
        finish_test("stalled_repeat_frame");

        start_test();
        inst_model[0] = random_desc();
        write_entry(SEL_INST, 0, WR_DW'(inst_model[0]));
        inst_count = '0;
        repeat (4) @(posedge clk);
        #1;
        predict_frame(0);
        pulse_frame_start();
        run_frame(1'b1);
        finish_test("camera_only_frame");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: src.f
src/geom_pkg.sv
src/scene_pkg.sv
src/scene_ram.sv
src/fetch_counter.sv
src/feed_sequencer.sv
src/triangle_assembler.sv
src/frame_feeder.sv
bench/frame_feeder_tb.sv

// File: src/feed_sequencer.sv
module feed_sequencer
    import geom_pkg::*, scene_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 scene_ready,
    input  logic [INST_AW-1:0]   inst_count,
    input  logic                 frame_start,
    input  logic                 wait_done,
    input  logic [TRI_CNT_W-1:0] tri_idx,
    input  logic [INST_AW-1:0]   inst_idx,
    input  logic                 last_tri,
    input  logic                 last_inst,
    input  logic                 slot_free,
    input  inst_desc_t           desc,
    input  tri_idx_t             tri_in,
    output logic                 wr_ready,
    output logic                 frame_done,
    output logic [INST_AW-1:0]   inst_last,
    output logic [INST_AW-1:0]   inst_addr,
    output logic [TRI_AW-1:0]    tri_addr,
    output logic [VERT_AW-1:0]   vert_addr,
    output logic                 start_wait,
    output logic                 step_tri,
    output logic                 clr_tri,
    output logic                 step_inst,
    output logic                 clr_inst,
    output logic                 cap_desc,
    output logic                 cap_v0,
    output logic                 cap_v1,
    output logic                 cap_v2,
    output logic                 emit,
    output setup_kind_t          emit_kind
);

    typedef enum logic [3:0] {
        IDLE,
        LOAD_DESC,
        EMIT_CAMERA,
        REQUEST_TRI,
        WAIT_TRI,
        FETCH_VERT,
        CAPTURE,
        EMIT_TRI,
        DONE
    } state_t;

    state_t               state;
    state_t               state_nxt;
    logic                 scene_ready_s1;
    logic                 scene_ready_s2;
    logic [INST_AW-1:0]   inst_count_s1;
    logic                 desc_req;
    logic [1:0]           vphase;
    tri_idx_t             tri_q;
    vidx_t                vidx_sel;

    // host side is asynchronous
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scene_ready_s1 <= 1'b0;
            scene_ready_s2 <= 1'b0;
            inst_count_s1  <= '0;
            inst_last      <= '0;
        end else begin
            scene_ready_s1 <= scene_ready;
            scene_ready_s2 <= scene_ready_s1;
            inst_count_s1  <= inst_count;
            inst_last      <= inst_count_s1;
        end
    end

    always_comb begin
        state_nxt  = state;
        start_wait = 1'b0;
        step_tri   = 1'b0;
        clr_tri    = 1'b0;
        step_inst  = 1'b0;
        clr_inst   = 1'b0;
        cap_desc   = 1'b0;
        cap_v0     = 1'b0;
        cap_v1     = 1'b0;
        cap_v2     = 1'b0;
        emit       = 1'b0;
        emit_kind  = KIND_TRIANGLE;
        case (state)
            IDLE: begin
                if (scene_ready_s2) begin
                    clr_tri   = 1'b1;
                    clr_inst  = 1'b1;
                    state_nxt = LOAD_DESC;
                end
            end
            LOAD_DESC: begin
                start_wait = desc_req && slot_free;
                if (wait_done) begin
                    cap_desc  = 1'b1;
                    // record 0 is the camera
                    state_nxt = (inst_idx == '0) ? EMIT_CAMERA : REQUEST_TRI;
                end
            end
            EMIT_CAMERA: begin
                emit_kind = KIND_CAMERA;
                if (slot_free) begin
                    emit = 1'b1;
                    if (last_inst) begin
                        state_nxt = DONE;
                    end else begin
                        step_inst = 1'b1;
                        clr_tri   = 1'b1;
                        state_nxt = LOAD_DESC;
                    end
                end
            end
            REQUEST_TRI: begin
                if (slot_free) begin
                    start_wait = 1'b1;
                    state_nxt  = WAIT_TRI;
                end
            end
            WAIT_TRI: begin
                if (wait_done) begin
                    state_nxt = FETCH_VERT;
                end
            end
            FETCH_VERT: begin
                // v0 data lands as the v2 address goes out
                if (vphase == 2'd2) begin
                    start_wait = 1'b1;
                    cap_v0     = 1'b1;
                    state_nxt  = CAPTURE;
                end
            end
            CAPTURE: begin
                cap_v1 = !wait_done;
                cap_v2 = wait_done;
                if (wait_done) begin
                    state_nxt = EMIT_TRI;
                end
            end
            EMIT_TRI: begin
                if (slot_free) begin
                    emit = 1'b1;
                    if (!last_tri) begin
                        step_tri  = 1'b1;
                        state_nxt = REQUEST_TRI;
                    end else if (last_inst) begin
                        state_nxt = DONE;
                    end else begin
                        step_inst = 1'b1;
                        clr_tri   = 1'b1;
                        state_nxt = LOAD_DESC;
                    end
                end
            end
            DONE: begin
                if (frame_done && frame_start) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            desc_req   <= 1'b0;
            vphase     <= '0;
            frame_done <= 1'b0;
        end else begin
            state <= state_nxt;
            // one descriptor read per entry into LOAD_DESC
            if (state != LOAD_DESC) begin
                desc_req <= (state_nxt == LOAD_DESC);
            end else if (start_wait) begin
                desc_req <= 1'b0;
            end
            vphase <= (state == FETCH_VERT) ? vphase + 2'd1 : 2'd0;
            // raised once the last packet has left
            if (state == DONE && !frame_done && slot_free) begin
                frame_done <= 1'b1;
            end else if (state == DONE && frame_done && frame_start) begin
                frame_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == WAIT_TRI && wait_done) begin
            tri_q <= tri_in;
        end
    end

    always_comb begin
        case (vphase)
            2'd0:    vidx_sel = tri_q.i0;
            2'd1:    vidx_sel = tri_q.i1;
            default: vidx_sel = tri_q.i2;
        endcase
    end

    assign wr_ready  = (state == IDLE) || (state == DONE);
    assign inst_addr = inst_idx;
    assign tri_addr  = desc.tri_base + TRI_AW'(tri_idx);
    assign vert_addr = desc.vert_base + VERT_AW'(vidx_sel);

    // output slot stays drained for the whole done phase
    done_only_when_drained: assert property (
        @(posedge clk) disable iff (rst)
        frame_done |-> slot_free
    ) else $error("feed_sequencer: frame_done with a packet still pending");

endmodule

// File: src/fetch_counter.sv
module fetch_counter
    import scene_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start_wait,
    input  logic                 step_tri,
    input  logic                 clr_tri,
    input  logic                 step_inst,
    input  logic                 clr_inst,
    input  logic [TRI_CNT_W-1:0] tri_last_count,
    input  logic [INST_AW-1:0]   inst_last,
    output logic                 wait_done,
    output logic [TRI_CNT_W-1:0] tri_idx,
    output logic [INST_AW-1:0]   inst_idx,
    output logic                 last_tri,
    output logic                 last_inst
);

    logic [WAIT_W-1:0] wait_cnt;

    // counts down from READ_LAT, done on the final count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (start_wait) begin
            wait_cnt <= WAIT_W'(READ_LAT);
        end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    assign wait_done = (wait_cnt == WAIT_W'(1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tri_idx  <= '0;
            inst_idx <= '0;
        end else begin
            if (clr_tri) begin
                tri_idx <= '0;
            end else if (step_tri) begin
                tri_idx <= tri_idx + 1'b1;
            end
            if (clr_inst) begin
                inst_idx <= '0;
            end else if (step_inst) begin
                inst_idx <= inst_idx + 1'b1;
            end
        end
    end

    assign last_tri  = (tri_idx == tri_last_count);
    assign last_inst = (inst_idx == inst_last);

    // next triangle only once its reads have landed
    no_step_during_wait: assert property (
        @(posedge clk) disable iff (rst)
        step_tri |-> (wait_cnt == '0)
    ) else $error("fetch_counter: step_tri while wait timer runs");

endmodule

// File: src/frame_feeder.sv
module frame_feeder
    import geom_pkg::*, scene_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_valid,
    input  scene_write_t       wr,
    input  logic               scene_ready,
    input  logic [INST_AW-1:0] inst_count,
    input  logic               setup_ready,
    input  logic               frame_start,
    output logic               wr_ready,
    output logic               setup_valid,
    output setup_pkt_t         setup,
    output logic               frame_done
);

    logic [INST_AW-1:0]   inst_addr;
    logic [TRI_AW-1:0]    tri_addr;
    logic [VERT_AW-1:0]   vert_addr;
    inst_desc_t           desc;
    tri_idx_t             tri_data;
    vertex_t              vert_data;
    logic                 start_wait;
    logic                 step_tri;
    logic                 clr_tri;
    logic                 step_inst;
    logic                 clr_inst;
    logic                 wait_done;
    logic [TRI_CNT_W-1:0] tri_idx;
    logic [INST_AW-1:0]   inst_idx;
    logic [INST_AW-1:0]   inst_last;
    logic                 last_tri;
    logic                 last_inst;
    logic                 cap_desc;
    logic                 cap_v0;
    logic                 cap_v1;
    logic                 cap_v2;
    logic                 emit;
    setup_kind_t          emit_kind;
    logic                 slot_free;

    scene_ram #(.payload_t(inst_desc_t), .AW(INST_AW), .TABLE(SEL_INST)) inst_ram_inst (
        .clk(clk), .rst(rst), .wr_valid(wr_valid), .wr_ready(wr_ready), .wr(wr),
        .rd_addr(inst_addr), .rd_data(desc)
    );

    scene_ram #(.payload_t(tri_idx_t), .AW(TRI_AW), .TABLE(SEL_TRI)) tri_ram_inst (
        .clk(clk), .rst(rst), .wr_valid(wr_valid), .wr_ready(wr_ready), .wr(wr),
        .rd_addr(tri_addr), .rd_data(tri_data)
    );

    scene_ram #(.payload_t(vertex_t), .AW(VERT_AW), .TABLE(SEL_VERT)) vert_ram_inst (
        .clk(clk), .rst(rst), .wr_valid(wr_valid), .wr_ready(wr_ready), .wr(wr),
        .rd_addr(vert_addr), .rd_data(vert_data)
    );

    fetch_counter fetch_counter_inst (
        .clk(clk), .rst(rst), .start_wait(start_wait), .step_tri(step_tri),
        .clr_tri(clr_tri), .step_inst(step_inst), .clr_inst(clr_inst),
        .tri_last_count(desc.tri_count), .inst_last(inst_last), .wait_done(wait_done),
        .tri_idx(tri_idx), .inst_idx(inst_idx), .last_tri(last_tri), .last_inst(last_inst)
    );

    feed_sequencer feed_sequencer_inst (
        .clk(clk), .rst(rst), .scene_ready(scene_ready), .inst_count(inst_count),
        .frame_start(frame_start), .wait_done(wait_done), .tri_idx(tri_idx),
        .inst_idx(inst_idx), .last_tri(last_tri), .last_inst(last_inst),
        .slot_free(slot_free), .desc(desc), .tri_in(tri_data), .wr_ready(wr_ready),
        .frame_done(frame_done), .inst_last(inst_last), .inst_addr(inst_addr),
        .tri_addr(tri_addr), .vert_addr(vert_addr), .start_wait(start_wait),
        .step_tri(step_tri), .clr_tri(clr_tri), .step_inst(step_inst), .clr_inst(clr_inst),
        .cap_desc(cap_desc), .cap_v0(cap_v0), .cap_v1(cap_v1), .cap_v2(cap_v2),
        .emit(emit), .emit_kind(emit_kind)
    );

    triangle_assembler triangle_assembler_inst (
        .clk(clk), .rst(rst), .cap_desc(cap_desc), .desc(desc), .cap_v0(cap_v0),
        .cap_v1(cap_v1), .cap_v2(cap_v2), .vert_in(vert_data), .emit(emit),
        .emit_kind(emit_kind), .setup_ready(setup_ready), .slot_free(slot_free),
        .setup_valid(setup_valid), .setup(setup)
    );

endmodule

// File: src/geom_pkg.sv
package geom_pkg;

    // signed model/screen coordinate
    typedef logic signed [11:0] coord_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } color12_t;

    typedef struct packed {
        coord_t   x;
        coord_t   y;
        coord_t   z;
        color12_t color;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    // uniform scale, then offset
    typedef struct packed {
        logic [7:0] scale;
        coord_t     ox;
        coord_t     oy;
        coord_t     oz;
    } xform_t;

    typedef logic [7:0] vidx_t;

    // i0 sits in the high bits
    typedef struct packed {
        vidx_t i0;
        vidx_t i1;
        vidx_t i2;
    } tri_idx_t;

endpackage

// File: src/scene_pkg.sv
package scene_pkg;

    import geom_pkg::*;

    localparam int VERT_AW   = 10;
    localparam int TRI_AW    = 10;
    localparam int INST_AW   = 4;
    localparam int WR_AW     = 10;
    localparam int TRI_CNT_W = 8;

    // address to data latency of every table
    localparam int READ_LAT = 2;
    localparam int WAIT_W   = $clog2(READ_LAT + 1);

    // tri_count holds count minus one
    typedef struct packed {
        logic [VERT_AW-1:0]   vert_base;
        logic [TRI_AW-1:0]    tri_base;
        logic [TRI_CNT_W-1:0] tri_count;
        xform_t               xform;
        color12_t             bg_color;
    } inst_desc_t;

    localparam int WR_DW = $bits(inst_desc_t);

    typedef enum logic [1:0] {
        SEL_INST,
        SEL_TRI,
        SEL_VERT
    } table_sel_t;

    // payload right-aligned in data
    typedef struct packed {
        table_sel_t       sel;
        logic [WR_AW-1:0] addr;
        logic [WR_DW-1:0] data;
    } scene_write_t;

    typedef enum logic {
        KIND_CAMERA,
        KIND_TRIANGLE
    } setup_kind_t;

    typedef struct packed {
        setup_kind_t kind;
        xform_t      xform;
        color12_t    bg_color;
        triangle_t   triangle;
    } setup_pkt_t;

endpackage

// File: src/scene_ram.sv
module scene_ram
    import scene_pkg::*;
#(
    parameter type        payload_t = inst_desc_t,
    parameter int         AW        = INST_AW,
    parameter table_sel_t TABLE     = SEL_INST
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          wr_valid,
    input  logic          wr_ready,
    input  scene_write_t  wr,
    input  logic [AW-1:0] rd_addr,
    output payload_t      rd_data
);

    payload_t      mem [(1 << AW)];
    logic [AW-1:0] rd_addr_q;
    logic          wr_hit;

    // only writes aimed at this table
    assign wr_hit = wr_valid && wr_ready && (wr.sel == TABLE);

    always_ff @(posedge clk) begin
        if (wr_hit) begin
            mem[wr.addr[AW-1:0]] <= payload_t'(wr.data[$bits(payload_t)-1:0]);
        end
    end

    // registered address plus registered output, two cycles
    always_ff @(posedge clk) begin
        rd_addr_q <= rd_addr;
        rd_data   <= mem[rd_addr_q];
    end

    // host must stay inside the table
    wr_addr_in_range: assert property (
        @(posedge clk) disable iff (rst)
        wr_hit |-> ((wr.addr >> AW) == 0)
    ) else $error("scene_ram: write address %h out of range", wr.addr);

endmodule

// File: src/triangle_assembler.sv
module triangle_assembler
    import geom_pkg::*, scene_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cap_desc,
    input  inst_desc_t  desc,
    input  logic        cap_v0,
    input  logic        cap_v1,
    input  logic        cap_v2,
    input  vertex_t     vert_in,
    input  logic        emit,
    input  setup_kind_t emit_kind,
    input  logic        setup_ready,
    output logic        slot_free,
    output logic        setup_valid,
    output setup_pkt_t  setup
);

    xform_t    stage_xform;
    color12_t  stage_bg;
    triangle_t stage_tri;

    // staging fills while the output may still be waiting
    always_ff @(posedge clk) begin
        if (cap_desc) begin
            stage_xform <= desc.xform;
            stage_bg    <= desc.bg_color;
        end
        if (cap_v0) begin
            stage_tri.v0 <= vert_in;
        end
        if (cap_v1) begin
            stage_tri.v1 <= vert_in;
        end
        if (cap_v2) begin
            stage_tri.v2 <= vert_in;
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            setup.kind     <= emit_kind;
            setup.xform    <= stage_xform;
            setup.bg_color <= stage_bg;
            // camera packet carries no geometry
            setup.triangle <= (emit_kind == KIND_CAMERA) ? '0 : stage_tri;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            setup_valid <= 1'b0;
        end else if (emit) begin
            setup_valid <= 1'b1;
        end else if (setup_ready) begin
            setup_valid <= 1'b0;
        end
    end

    // empty or draining this cycle
    assign slot_free = !setup_valid || setup_ready;

    setup_held_stable: assert property (
        @(posedge clk) disable iff (rst)
        (setup_valid && !setup_ready) |=> (setup_valid && $stable(setup))
    ) else $error("triangle_assembler: setup changed under back-pressure");

endmodule
